/* compile.f */
src/lc3b_isa_pkg.sv
src/ooo_pkg.sv
src/issue_if.sv
src/issue_control.sv
src/reg_status.sv
src/reorder_buffer.sv
src/alu_stations.sv
src/ooo_core.sv
testbench/ooo_core_chk.sv
testbench/tb_ooo_core.sv

/* src/alu_stations.sv */
`timescale 1ns/10ps

module alu_stations
(
	input logic clk,
	input logic rst_n,
	issue_if.sink iss,
	output logic [ooo_pkg::num_alu_rs-1:0] busy,
	output ooo_pkg::cdb_t cdb
);

	localparam int n = ooo_pkg::num_alu_rs;

	lc3b_isa_pkg::lc3b_opcode op [n];
	lc3b_isa_pkg::lc3b_word vj [n];
	lc3b_isa_pkg::lc3b_word vk [n];
	ooo_pkg::rob_tag_t qj [n];
	ooo_pkg::rob_tag_t qk [n];
	ooo_pkg::rob_tag_t dest [n];
	logic [n-1:0] rj, rk;
	logic [n-1:0] wake_j, wake_k, load;
	logic dispatch;
	ooo_pkg::rs_id_t sel;
	lc3b_isa_pkg::lc3b_word alu_out;

	// CDB snoop and issue write per station
	always_comb
	begin
		for (int i = 0; i < n; i++)
		begin
			wake_j[i] = busy[i] && !rj[i] && cdb.valid && (cdb.tag == qj[i]);
			wake_k[i] = busy[i] && !rk[i] && cdb.valid && (cdb.tag == qk[i]);
			load[i] = iss.valid && (iss.station == ooo_pkg::rs_id_t'(i));
		end
	end

	// Lowest numbered ready station goes first
	always_comb
	begin
		dispatch = 1'b0;
		sel = '0;
		for (int i = n - 1; i >= 0; i--)
			if (busy[i] && rj[i] && rk[i])
			begin
				dispatch = 1'b1;
				sel = ooo_pkg::rs_id_t'(i);
			end
	end

	always_comb
	begin
		case (op[sel])
			lc3b_isa_pkg::op_add: alu_out = vj[sel] + vk[sel];
			lc3b_isa_pkg::op_and: alu_out = vj[sel] & vk[sel];
			lc3b_isa_pkg::op_not: alu_out = ~vj[sel];
			default: alu_out = vj[sel];
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= '0;
			rj <= '0;
			rk <= '0;
			cdb <= '0;
		end
		else
		begin
			for (int i = 0; i < n; i++)
			begin
				if (wake_j[i])
					rj[i] <= 1'b1;
				if (wake_k[i])
					rk[i] <= 1'b1;
				if (dispatch && sel == ooo_pkg::rs_id_t'(i))
					busy[i] <= 1'b0; // Freed as it leaves for the ALU
				if (load[i])
				begin
					busy[i] <= 1'b1;
					rj[i] <= iss.ready_j;
					rk[i] <= iss.ready_k;
				end
			end
			cdb.valid <= dispatch;
			cdb.tag <= dest[sel];
			cdb.data <= alu_out;
		end
	end

	// Station payload
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < n; i++)
		begin
			if (wake_j[i])
				vj[i] <= cdb.data;
			if (wake_k[i])
				vk[i] <= cdb.data;
			if (load[i])
			begin
				op[i] <= iss.op;
				vj[i] <= iss.vj;
				vk[i] <= iss.vk;
				qj[i] <= iss.qj;
				qk[i] <= iss.qk;
				dest[i] <= iss.dest;
			end
		end
	end

endmodule : alu_stations

/* src/issue_control.sv */
`timescale 1ns/10ps

module issue_control
(
	input lc3b_isa_pkg::lc3b_word instr,
	input logic instr_valid,
	input ooo_pkg::cdb_t cdb,
	input logic [ooo_pkg::num_alu_rs-1:0] rs_busy,
	input logic rob_full,
	input ooo_pkg::rob_tag_t rob_tag,
	input lc3b_isa_pkg::lc3b_word sr1_val, sr2_val, // ROB lookup results
	input logic sr1_rob_valid, sr2_rob_valid,
	input logic sr1_busy, sr2_busy,
	input ooo_pkg::rob_tag_t sr1_tag, sr2_tag,
	input lc3b_isa_pkg::lc3b_word sr1_data, sr2_data,
	output logic stall,
	issue_if.source iss,
	output logic rob_alloc,
	output lc3b_isa_pkg::lc3b_reg rob_dest,
	output lc3b_isa_pkg::lc3b_reg sr1, sr2, reg_dest,
	output logic reg_claim
);

	lc3b_isa_pkg::lc3b_opcode opcode;
	lc3b_isa_pkg::lc3b_word imm_sext;
	lc3b_isa_pkg::lc3b_reg dest_reg;
	logic is_alu;
	logic issue;

	assign opcode = lc3b_isa_pkg::lc3b_opcode'(instr[15:12]);
	assign dest_reg = instr[11:9];
	assign sr1 = instr[8:6];
	assign sr2 = instr[2:0];
	assign imm_sext = {{($bits(lc3b_isa_pkg::lc3b_word) - lc3b_isa_pkg::imm5_width)
		{instr[lc3b_isa_pkg::imm5_width-1]}}, instr[lc3b_isa_pkg::imm5_width-1:0]};

	assign is_alu = (opcode == lc3b_isa_pkg::op_add) || (opcode == lc3b_isa_pkg::op_and) ||
		(opcode == lc3b_isa_pkg::op_not);

	// Hold the source while nothing can be accepted
	assign stall = !instr_valid || rob_full || (is_alu && (&rs_busy));
	assign issue = !stall && is_alu; // Other opcodes just drain

	// Claim the destination in both rename structures
	assign rob_alloc = issue;
	assign rob_dest = dest_reg;
	assign reg_claim = issue;
	assign reg_dest = dest_reg;

	assign iss.valid = issue;
	assign iss.op = opcode;
	assign iss.dest = rob_tag;

	// Lowest free station
	always_comb
	begin
		iss.station = '0;
		for (int i = ooo_pkg::num_alu_rs - 1; i >= 0; i--)
			if (!rs_busy[i])
				iss.station = ooo_pkg::rs_id_t'(i);
	end

	// J operand comes from SR1
	always_comb
	begin
		iss.vj = '0;
		iss.qj = '0;
		iss.ready_j = 1'b1;
		if (!sr1_busy)
			iss.vj = sr1_data;
		else if (cdb.valid && cdb.tag == sr1_tag) // Result on the bus right now
			iss.vj = cdb.data;
		else if (sr1_rob_valid)
			iss.vj = sr1_val;
		else
		begin
			iss.ready_j = 1'b0;
			iss.qj = sr1_tag;
		end
	end

	// K operand from the immediate or SR2
	always_comb
	begin
		iss.vk = '0;
		iss.qk = '0;
		iss.ready_k = 1'b1;
		if (opcode == lc3b_isa_pkg::op_not)
			iss.vk = '0; // NOT has no second operand
		else if (instr[5])
			iss.vk = imm_sext;
		else if (!sr2_busy)
			iss.vk = sr2_data;
		else if (cdb.valid && cdb.tag == sr2_tag)
			iss.vk = cdb.data;
		else if (sr2_rob_valid)
			iss.vk = sr2_val;
		else
		begin
			iss.ready_k = 1'b0;
			iss.qk = sr2_tag;
		end
	end

endmodule : issue_control

/* src/issue_if.sv */
`timescale 1ns/10ps

interface issue_if;

	logic valid;
	ooo_pkg::rs_id_t station; // Always a free station
	lc3b_isa_pkg::lc3b_opcode op;
	lc3b_isa_pkg::lc3b_word vj, vk;
	ooo_pkg::rob_tag_t qj, qk; // Producer tags when not ready
	logic ready_j, ready_k;
	ooo_pkg::rob_tag_t dest;

	modport source (output valid, station, op, vj, vk, qj, qk, ready_j, ready_k, dest);
	modport sink (input valid, station, op, vj, vk, qj, qk, ready_j, ready_k, dest);

endinterface : issue_if

/* src/lc3b_isa_pkg.sv */
package lc3b_isa_pkg;

	// Immediate field of ADD/AND
	localparam int imm5_width = 5;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	// Only the ALU group and BR have names
	typedef enum logic [3:0]
	{
		op_br = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_not = 4'b1001
	} lc3b_opcode;

endpackage : lc3b_isa_pkg

/* src/ooo_core.sv */
`timescale 1ns/10ps

module ooo_core
(
	input logic clk,
	input logic rst_n,
	input lc3b_isa_pkg::lc3b_word instr,
	input logic instr_valid,
	output logic stall,
	output logic commit_valid,
	output lc3b_isa_pkg::lc3b_reg commit_reg,
	output lc3b_isa_pkg::lc3b_word commit_value
);

	ooo_pkg::cdb_t cdb;
	logic [ooo_pkg::num_alu_rs-1:0] rs_busy;
	logic rob_full, rob_alloc, reg_claim;
	ooo_pkg::rob_tag_t rob_tag, commit_tag;
	ooo_pkg::rob_tag_t sr1_tag, sr2_tag;
	lc3b_isa_pkg::lc3b_reg rob_dest, sr1, sr2, reg_dest;
	lc3b_isa_pkg::lc3b_word sr1_val, sr2_val, sr1_data, sr2_data;
	logic sr1_rob_valid, sr2_rob_valid, sr1_busy, sr2_busy;

	issue_if iss_bus ();

	issue_control u_issue (.instr, .instr_valid, .cdb, .rs_busy, .rob_full, .rob_tag,
		.sr1_val, .sr2_val, .sr1_rob_valid, .sr2_rob_valid, .sr1_busy, .sr2_busy,
		.sr1_tag, .sr2_tag, .sr1_data, .sr2_data, .stall, .iss(iss_bus.source),
		.rob_alloc, .rob_dest, .sr1, .sr2, .reg_dest, .reg_claim);

	reg_status u_regs (.clk, .rst_n, .sr1, .sr2, .sr1_busy, .sr2_busy, .sr1_tag, .sr2_tag,
		.sr1_data, .sr2_data, .claim(reg_claim), .claim_reg(reg_dest), .claim_tag(rob_tag),
		.commit_valid, .commit_reg, .commit_tag, .commit_value);

	// Lookups follow the rename tags of the two sources
	reorder_buffer u_rob (.clk, .rst_n, .alloc(rob_alloc), .alloc_dest(rob_dest),
		.full(rob_full), .tail_tag(rob_tag), .cdb, .look1_tag(sr1_tag), .look2_tag(sr2_tag),
		.look1_value(sr1_val), .look2_value(sr2_val), .look1_valid(sr1_rob_valid),
		.look2_valid(sr2_rob_valid), .commit_valid, .commit_reg, .commit_tag, .commit_value);

	alu_stations u_alu (.clk, .rst_n, .iss(iss_bus.sink), .busy(rs_busy), .cdb);

endmodule : ooo_core

/* src/ooo_pkg.sv */
package ooo_pkg;

	// Reorder buffer size matches the tag width
	localparam int rob_depth = 8;

	// ALU reservation stations
	localparam int num_alu_rs = 3;

	typedef logic [2:0] rob_tag_t;
	typedef logic [1:0] rs_id_t;

	// Common data bus carries one result per cycle
	typedef struct packed
	{
		logic valid;
		rob_tag_t tag; // ROB entry that produced the value
		lc3b_isa_pkg::lc3b_word data;
	} cdb_t;

endpackage : ooo_pkg

/* src/reg_status.sv */
`timescale 1ns/10ps

module reg_status
(
	input logic clk,
	input logic rst_n,
	input lc3b_isa_pkg::lc3b_reg sr1, sr2,
	output logic sr1_busy, sr2_busy,
	output ooo_pkg::rob_tag_t sr1_tag, sr2_tag,
	output lc3b_isa_pkg::lc3b_word sr1_data, sr2_data,
	input logic claim,
	input lc3b_isa_pkg::lc3b_reg claim_reg,
	input ooo_pkg::rob_tag_t claim_tag,
	input logic commit_valid,
	input lc3b_isa_pkg::lc3b_reg commit_reg,
	input ooo_pkg::rob_tag_t commit_tag,
	input lc3b_isa_pkg::lc3b_word commit_value
);

	lc3b_isa_pkg::lc3b_word regs [8];
	logic [7:0] busy;
	ooo_pkg::rob_tag_t tags [8]; // Newest producer of each register

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= '0;
			for (int i = 0; i < 8; i++)
			begin
				regs[i] <= '0;
				tags[i] <= '0;
			end
		end
		else
		begin
			if (commit_valid)
			begin
				regs[commit_reg] <= commit_value;
				// A younger claim keeps the register renamed
				if (busy[commit_reg] && tags[commit_reg] == commit_tag)
					busy[commit_reg] <= 1'b0;
			end
			if (claim) // Claim wins over a same-cycle commit
			begin
				busy[claim_reg] <= 1'b1;
				tags[claim_reg] <= claim_tag;
			end
		end
	end

	assign sr1_busy = busy[sr1];
	assign sr2_busy = busy[sr2];
	assign sr1_tag = tags[sr1];
	assign sr2_tag = tags[sr2];
	assign sr1_data = regs[sr1];
	assign sr2_data = regs[sr2];

endmodule : reg_status

/* src/reorder_buffer.sv */
`timescale 1ns/10ps

module reorder_buffer
(
	input logic clk,
	input logic rst_n,
	input logic alloc,
	input lc3b_isa_pkg::lc3b_reg alloc_dest,
	output logic full,
	output ooo_pkg::rob_tag_t tail_tag,
	input ooo_pkg::cdb_t cdb,
	input ooo_pkg::rob_tag_t look1_tag, look2_tag,
	output lc3b_isa_pkg::lc3b_word look1_value, look2_value,
	output logic look1_valid, look2_valid,
	output logic commit_valid,
	output lc3b_isa_pkg::lc3b_reg commit_reg,
	output ooo_pkg::rob_tag_t commit_tag,
	output lc3b_isa_pkg::lc3b_word commit_value
);

	lc3b_isa_pkg::lc3b_reg dest [ooo_pkg::rob_depth];
	lc3b_isa_pkg::lc3b_word value [ooo_pkg::rob_depth];
	logic [ooo_pkg::rob_depth-1:0] done;
	ooo_pkg::rob_tag_t head, tail;
	logic [$clog2(ooo_pkg::rob_depth):0] count; // 0 to rob_depth

	assign full = (count == ooo_pkg::rob_depth);
	assign tail_tag = tail;

	// Oldest entry retires once its result is in
	assign commit_valid = (count != '0) && done[head];
	assign commit_reg = dest[head];
	assign commit_tag = head;
	assign commit_value = value[head];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
			done <= '0;
		end
		else
		begin
			if (cdb.valid)
				done[cdb.tag] <= 1'b1;
			if (alloc)
			begin
				done[tail] <= 1'b0;
				tail <= tail + 1'b1; // Wraps at rob_depth
			end
			if (commit_valid)
				head <= head + 1'b1;
			count <= count + alloc - commit_valid;
		end
	end

	// Payload
	always_ff @(posedge clk)
	begin
		if (alloc)
			dest[tail] <= alloc_dest;
		if (cdb.valid)
			value[cdb.tag] <= cdb.data;
	end

	// Operand lookup for issue
	assign look1_value = value[look1_tag];
	assign look2_value = value[look2_tag];
	assign look1_valid = done[look1_tag];
	assign look2_valid = done[look2_tag];

endmodule : reorder_buffer

/* testbench/ooo_core_chk.sv */
`timescale 1ns/10ps

module ooo_core_chk
(
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	input logic stall,
	input logic commit_valid,
	input logic cdb_valid,
	input ooo_pkg::rob_tag_t cdb_tag
);

	int unsigned fail_count = 0; // Read by the testbench at the end

	// No accept without a request
	stall_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!instr_valid |-> stall)
	else
	begin
		$error("stall low while instr_valid is low");
		fail_count++;
	end

	no_commit_in_reset: assert property (@(posedge clk) !rst_n |-> !commit_valid)
	else
	begin
		$error("commit_valid high during reset");
		fail_count++;
	end

	// Each ROB entry produces exactly once
	cdb_tag_changes: assert property (@(posedge clk) disable iff (!rst_n)
		cdb_valid |=> !(cdb_valid && cdb_tag == $past(cdb_tag)))
	else
	begin
		$error("CDB broadcast tag %0d on two cycles in a row", cdb_tag);
		fail_count++;
	end

endmodule : ooo_core_chk

bind ooo_core ooo_core_chk u_chk (.clk, .rst_n, .instr_valid, .stall, .commit_valid,
	.cdb_valid(cdb.valid), .cdb_tag(cdb.tag));

/* testbench/ooo_testdata.txt */
// Kind digit (A after a random gap, B back to back), instruction word, expected commit value
// Non-ALU words expect nothing and carry 0000
A12250005 // ADD R1, R0, #5
A143DFFFD // ADD R2, R0, #-3
A56270000 // AND R3, R0, #7
A16420002 // ADD R3, R1, R2
A18E40006 // ADD R4, R3, #4
A5B010004 // AND R5, R4, R1
A9D7FFFFB // NOT R6, R5
A0E020000 // BR, consumed
A1F85FFFF // ADD R7, R6, R5
A91FF0000 // NOT R0, R7
A54BFFFFD // AND R2, R2, #-1
A60000000 // LDW, consumed
B12610006 // ADD R1, R1, #1 chain
B12610007
B12610008
B12610009
B1261000A
B1261000B
B1261000C
B1261000D
B1441001A // ADD R2, R1, R1
B96BFFFE5 // NOT R3, R2
B58C10005 // AND R4, R3, R1
B1AF0FFD5 // ADD R5, R3, #-16

/* testbench/tb_ooo_core.sv */
`timescale 1ns/10ps

module tb_ooo_core;

	localparam int max_tests = 64;

	logic clk = 1'b0;
	logic rst_n;
	lc3b_isa_pkg::lc3b_word instr;
	logic instr_valid;
	logic stall;
	logic commit_valid;
	lc3b_isa_pkg::lc3b_reg commit_reg;
	lc3b_isa_pkg::lc3b_word commit_value;

	logic [35:0] vectors [max_tests]; // {kind, instr, expected}
	lc3b_isa_pkg::lc3b_word model_regs [8];
	int exp_test [$];
	lc3b_isa_pkg::lc3b_reg exp_reg [$];
	lc3b_isa_pkg::lc3b_word exp_value [$];
	int num_tests, errors, passed, cycles, cycle_limit;
	int issued_alu, commits, t_idx;
	lc3b_isa_pkg::lc3b_reg r_exp;
	lc3b_isa_pkg::lc3b_word v_exp;
	logic burst_stalled = 1'b0;

	ooo_core DUT (.clk, .rst_n, .instr, .instr_valid, .stall, .commit_valid, .commit_reg,
		.commit_value);

	always #5 clk = ~clk;

	function automatic logic is_alu_op(input lc3b_isa_pkg::lc3b_word word_in);
		return word_in[15:12] == 4'b0001 || word_in[15:12] == 4'b0101 ||
			word_in[15:12] == 4'b1001;
	endfunction

	// ISA semantics against the model registers
	function automatic lc3b_isa_pkg::lc3b_word isa_result(
		input lc3b_isa_pkg::lc3b_word word_in);
		lc3b_isa_pkg::lc3b_word a, b;
		a = model_regs[word_in[8:6]];
		b = word_in[5] ? {{11{word_in[4]}}, word_in[4:0]} : model_regs[word_in[2:0]];
		case (word_in[15:12])
			4'b0001: return a + b;
			4'b0101: return a & b;
			default: return ~a; // NOT
		endcase
	endfunction

	// Returns at the posedge that takes the instruction
	task automatic wait_accept(input logic burst);
		logic taken;
		taken = 1'b0;
		while (!taken)
		begin
			@(posedge clk);
			taken = !stall;
			if (stall && burst)
				burst_stalled = 1'b1;
			if (!taken)
				@(negedge clk);
		end
	endtask

	always @(posedge clk)
	begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit)
		begin
			$display("Timeout: run still busy after %0d cycles", cycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// Commit outputs are stable at the falling edge
	always @(negedge clk)
	begin
		if (rst_n && commit_valid)
		begin
			commits++;
			if (exp_reg.size() == 0)
			begin
				$display("Commit to R%0d at %0t with no instruction outstanding",
					commit_reg, $time);
				errors++;
			end
			else
			begin
				t_idx = exp_test.pop_front();
				r_exp = exp_reg.pop_front();
				v_exp = exp_value.pop_front();
				if (commit_reg != r_exp)
					$display("** Error at %0t: commit_reg = %0d, expected %0d", $time,
						commit_reg, r_exp);
				if (commit_value != v_exp)
					$display("** Error at %0t: commit_value = %h, expected %h", $time,
						commit_value, v_exp);
				if (commit_reg == r_exp && commit_value == v_exp)
					passed++;
				else
					errors++;
				$display("test %0d: R%0d = %h", t_idx, commit_reg, commit_value);
			end
		end
	end

	initial
	begin
		int gap;
		lc3b_isa_pkg::lc3b_word word_now, model_val;
		void'($urandom(32'h6a7d0fab));
		rst_n = 1'b0;
		instr = '0;
		instr_valid = 1'b0;
		for (int r = 0; r < 8; r++)
			model_regs[r] = '0;
		$readmemh("testbench/ooo_testdata.txt", vectors);
		num_tests = 0;
		while (num_tests < max_tests && (vectors[num_tests][35:32] == 4'ha ||
			vectors[num_tests][35:32] == 4'hb))
			num_tests++;
		cycle_limit = 40 * num_tests;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		for (int i = 0; i < num_tests; i++)
		begin
			gap = vectors[i][32] ? 0 : $urandom % 4; // Kind B runs back to back
			if (gap > 0)
			begin
				instr_valid = 1'b0;
				instr = '0;
				repeat (gap) @(negedge clk);
			end
			word_now = vectors[i][31:16];
			instr = word_now;
			instr_valid = 1'b1;
			wait_accept(vectors[i][32]);
			if (is_alu_op(word_now))
			begin
				model_val = isa_result(word_now);
				if (model_val != vectors[i][15:0])
				begin
					$display("test %0d: data file expects %h but the ISA model gives %h", i,
						vectors[i][15:0], model_val);
					errors++;
				end
				exp_test.push_back(i);
				exp_reg.push_back(word_now[11:9]);
				exp_value.push_back(vectors[i][15:0]);
				model_regs[word_now[11:9]] = model_val;
				issued_alu++;
			end
			else
			begin
				$display("test %0d: opcode %h consumed", i, word_now[15:12]);
				passed++;
			end
			@(negedge clk);
		end
		instr_valid = 1'b0;
		instr = '0;

		while (exp_reg.size() != 0)
			@(negedge clk);
		repeat (10) @(negedge clk); // Room for any stray commit
		if (commits != issued_alu)
		begin
			$display("%0d commits seen for %0d issued ALU instructions", commits, issued_alu);
			errors++;
		end
		if (!burst_stalled)
		begin
			$display("The back-to-back burst never raised stall");
			errors++;
		end
		errors += DUT.u_chk.fail_count;
		$display("%0d tests, %0d passed, %0d errors", num_tests, passed, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule : tb_ooo_core
